// ==== include/frame_fifo_config.svh ====
/*
 * frame FIFO configuration
 * sizes for the 64-bit receive frame FIFO and its status output
 */

`ifndef FRAME_FIFO_CONFIG_SVH
`define FRAME_FIFO_CONFIG_SVH

// data path of one stored word
`define FIFO_DATA_WIDTH   64
`define FIFO_KEEP_WIDTH   8

// 64 words of storage
`define FIFO_ADDR_WIDTH   6

// write side reports full this many words short of the depth
`define FIFO_FULL_MARGIN  4

// occupancy in sixteenths
`define FIFO_STATUS_WIDTH 4

`endif

// ==== hdl/frame_pkg.sv ====
/*
 * frame_pkg
 * stored word format of the frame FIFO and the byte-keep remainder coding
 */

`default_nettype none

`include "frame_fifo_config.svh"

package frame_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`FIFO_KEEP_WIDTH-1:0] keep_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

  // valid bytes in a word minus one
  typedef logic [2:0] rem_t;

  // one RAM entry, eof and remainder sit above the data
  typedef struct packed {
    logic  eof;
    rem_t  rem;
    data_t data;
  } ram_word_t;

  // keep mask is contiguous from bit 0, so the top set bit is the remainder
  function automatic rem_t keep_to_rem(input keep_t keep);
    rem_t rem;
    rem = '0;
    for (int i = 1; i < `FIFO_KEEP_WIDTH; i++) begin
      if (keep[i]) begin
        rem = rem_t'(i);
      end
    end
    return rem;
  endfunction

  // rebuild a contiguous keep mask from the remainder
  function automatic keep_t rem_to_keep(input rem_t rem);
    keep_t keep;
    for (int i = 0; i < `FIFO_KEEP_WIDTH; i++) begin
      keep[i] = (i <= int'(rem));
    end
    return keep;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/fifo_ctrl_pkg.sv ====
/*
 * fifo_ctrl_pkg
 * read FSM states and occupancy status type of the frame FIFO
 */

`default_nettype none

`include "frame_fifo_config.svh"

package fifo_ctrl_pkg;

  // read side FSM
  typedef enum logic [1:0] {
    rd_idle   = 2'd0,
    rd_fetch  = 2'd1,
    rd_stream = 2'd2
  } rd_state_e;

  // occupancy in sixteenths of the depth
  typedef logic [`FIFO_STATUS_WIDTH-1:0] status_t;

endpackage

`default_nettype wire

// ==== hdl/ram_wr_if.sv ====
/*
 * ram_wr_if
 * one RAM write per cycle from the frame writer into the word memory
 */

`default_nettype none

`include "frame_fifo_config.svh"

interface ram_wr_if
  import frame_pkg::*;
(
  input wire logic clk
);

  // no handshake, a write happens whenever we is high
  logic      we;
  addr_t     addr;
  ram_word_t word;

  modport writer (input clk, output we, output addr, output word);
  modport ram    (input clk, input we, input addr, input word);

endinterface

`default_nettype wire

// ==== hdl/frame_writer.sv ====
/*
 * frame_writer
 * write stage of the receive frame FIFO, registers beats into the RAM,
 * commits good frames and rolls back bad or oversized ones
 */

`default_nettype none

`include "frame_fifo_config.svh"

module frame_writer
  import frame_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire logic  wr_axis_aclk,
  input  wire logic  rd_sreset,
  input  wire data_t wr_axis_tdata,
  input  wire keep_t wr_axis_tkeep,
  input  wire logic  wr_axis_tvalid,
  input  wire logic  wr_axis_tlast,
  input  wire logic  wr_axis_tuser,
  input  wire addr_t rel_addr,
  ram_wr_if.writer   ram,
  output logic       commit_strobe,
  output addr_t      commit_addr,
  output logic       fifo_full,
  output status_t    fifo_status
);

  localparam int unsigned DEPTH       = 1 << `FIFO_ADDR_WIDTH;
  localparam int unsigned FULL_THRESH = DEPTH - `FIFO_FULL_MARGIN;

  addr_t wr_ptr;
  addr_t wr_ptr_inc;
  addr_t frame_start;
  addr_t used;
  logic  marked;
  logic  at_thresh;
  logic  drop_now;

  // ----------------------------------------------------------
  // occupancy against the reader's release point
  // ----------------------------------------------------------
  assign wr_ptr_inc = wr_ptr + 1'b1;
  assign used       = wr_ptr - rel_addr;
  assign at_thresh  = (used >= addr_t'(FULL_THRESH));

  // once a frame hits the threshold none of its beats are stored
  assign drop_now   = marked | at_thresh;

  // ----------------------------------------------------------
  // pointers, commit and status
  // ----------------------------------------------------------
  always_ff @(posedge wr_axis_aclk) begin
    if (rd_sreset) begin
      wr_ptr        <= '0;
      frame_start   <= '0;
      marked        <= 1'b0;
      commit_strobe <= 1'b0;
      commit_addr   <= '0;
      ram.we        <= 1'b0;
      fifo_full     <= 1'b0;
      fifo_status   <= '0;
    end else begin
      ram.we        <= wr_axis_tvalid & ~drop_now;
      commit_strobe <= 1'b0;
      fifo_full     <= at_thresh;
      // top bits of the used count give sixteenths
      fifo_status   <= status_t'(used[`FIFO_ADDR_WIDTH-1 -: `FIFO_STATUS_WIDTH]);
      if (wr_axis_tvalid) begin
        if (wr_axis_tlast) begin
          marked <= 1'b0;
          if (wr_axis_tuser && !drop_now) begin
            // good frame that fit, publish its end
            wr_ptr        <= wr_ptr_inc;
            frame_start   <= wr_ptr_inc;
            commit_addr   <= wr_ptr_inc;
            commit_strobe <= 1'b1;
          end else begin
            // bad or oversized, next frame overwrites it
            wr_ptr <= frame_start;
          end
        end else if (drop_now) begin
          marked <= 1'b1;
        end else begin
          wr_ptr <= wr_ptr_inc;
        end
      end
    end
  end

  // write payload, remainder is only meaningful on the eof word
  always_ff @(posedge wr_axis_aclk) begin
    ram.addr <= wr_ptr;
    ram.word <= '{eof: wr_axis_tlast, rem: keep_to_rem(wr_axis_tkeep), data: wr_axis_tdata};
  end

  // the reader must never release past what was written
  // so the count stays at or below the threshold and well inside depth - 1
  a_used_bound: assert property (
    @(posedge wr_axis_aclk) disable iff (rd_sreset)
    used <= addr_t'(FULL_THRESH)
  ) else $error("frame_writer: used count %0d out of range", used);

endmodule

`default_nettype wire

// ==== hdl/frame_ram.sv ====
/*
 * frame_ram
 * simple dual-port word memory, registered read with write bypass
 */

`default_nettype none

`include "frame_fifo_config.svh"

module frame_ram
  import frame_pkg::*;
(
  input  wire logic  wr_axis_aclk,
  ram_wr_if.ram      ram,
  input  wire logic  rd_en,
  input  wire addr_t rd_addr,
  output ram_word_t  rd_word
);

  localparam int unsigned DEPTH = 1 << `FIFO_ADDR_WIDTH;

  ram_word_t mem [DEPTH];

  // write port runs on the interface clock
  always_ff @(posedge ram.clk) begin
    if (ram.we) begin
      mem[ram.addr] <= ram.word;
    end
  end

  // read port holds its word while rd_en is low
  // a read of the word being written returns the new word
  always_ff @(posedge wr_axis_aclk) begin
    if (rd_en) begin
      if (ram.we && (ram.addr == rd_addr)) begin
        rd_word <= ram.word;
      end else begin
        rd_word <= mem[rd_addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/frame_reader.sv ====
/*
 * frame_reader
 * read stage of the frame FIFO, streams committed frames with valid/ready
 * and reports how far complete frames have been delivered
 */

`default_nettype none

`include "frame_fifo_config.svh"

module frame_reader
  import frame_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire logic      wr_axis_aclk,
  input  wire logic      rd_sreset,
  input  wire logic      commit_strobe,
  input  wire addr_t     commit_addr,
  input  wire ram_word_t rd_word,
  input  wire logic      rd_axis_tready,
  output logic           rd_en,
  output addr_t          rd_addr,
  output addr_t          rel_addr,
  output data_t          rd_axis_tdata,
  output keep_t          rd_axis_tkeep,
  output logic           rd_axis_tvalid,
  output logic           rd_axis_tlast
);

  rd_state_e rd_state;
  rd_state_e rd_state_nxt;

  addr_t avail_ptr;
  addr_t avail_now;
  addr_t rd_ptr;
  addr_t dlv_ptr;
  logic  pending;
  logic  word_vld;
  logic  load_out;
  logic  out_fire;

  // ----------------------------------------------------------
  // availability and pipeline moves
  // ----------------------------------------------------------
  // take a commit in the cycle it arrives
  assign avail_now = commit_strobe ? commit_addr : avail_ptr;
  assign pending   = (rd_ptr != avail_now);

  assign rd_axis_tvalid = (rd_state == rd_stream);
  assign out_fire       = rd_axis_tvalid & rd_axis_tready;

  // RAM output register feeds the output register when it is free
  assign load_out = word_vld & (~rd_axis_tvalid | rd_axis_tready);

  // prefetch while the RAM register is empty or being drained
  assign rd_en   = pending & (~word_vld | load_out);
  assign rd_addr = rd_ptr;

  // ----------------------------------------------------------
  // read FSM
  // ----------------------------------------------------------
  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      rd_idle: begin
        if (rd_en) begin
          rd_state_nxt = rd_fetch;
        end
      end
      // first word lands in the RAM register
      rd_fetch: begin
        rd_state_nxt = rd_stream;
      end
      rd_stream: begin
        // output taken with nothing behind it
        if (out_fire && !word_vld) begin
          rd_state_nxt = rd_en ? rd_fetch : rd_idle;
        end
      end
      default: begin
        rd_state_nxt = rd_idle;
      end
    endcase
  end

  always_ff @(posedge wr_axis_aclk) begin
    if (rd_sreset) begin
      rd_state      <= rd_idle;
      avail_ptr     <= '0;
      rd_ptr        <= '0;
      dlv_ptr       <= '0;
      rel_addr      <= '0;
      word_vld      <= 1'b0;
      rd_axis_tlast <= 1'b0;
    end else begin
      rd_state <= rd_state_nxt;
      if (commit_strobe) begin
        avail_ptr <= commit_addr;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      word_vld <= rd_en | (word_vld & ~load_out);
      if (load_out) begin
        rd_axis_tlast <= rd_word.eof;
      end
      // space is handed back a whole frame at a time
      if (out_fire) begin
        dlv_ptr <= dlv_ptr + 1'b1;
        if (rd_axis_tlast) begin
          rel_addr <= dlv_ptr + 1'b1;
        end
      end
    end
  end

  // output payload, keep rebuilt on the eof word only
  always_ff @(posedge wr_axis_aclk) begin
    if (load_out) begin
      rd_axis_tdata <= rd_word.data;
      rd_axis_tkeep <= rd_word.eof ? rem_to_keep(rd_word.rem) : keep_t'('1);
    end
  end

  // a stalled beat holds until it is taken
  a_hold_stable: assert property (
    @(posedge wr_axis_aclk) disable iff (rd_sreset)
    rd_axis_tvalid && !rd_axis_tready |=>
      rd_axis_tvalid && $stable(rd_axis_tdata) && $stable(rd_axis_tkeep) &&
      $stable(rd_axis_tlast)
  ) else $error("frame_reader: output changed under back-pressure");

endmodule

`default_nettype wire

// ==== hdl/axis_frame_fifo.sv ====
/*
 * axis_frame_fifo
 * single-clock receive frame FIFO, 64-bit stream in and out,
 * releases only complete good frames
 */

`default_nettype none

`include "frame_fifo_config.svh"

module axis_frame_fifo
  import frame_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire logic    wr_axis_aclk,
  input  wire logic    rd_sreset,
  // write side never stalls
  input  wire data_t   wr_axis_tdata,
  input  wire keep_t   wr_axis_tkeep,
  input  wire logic    wr_axis_tvalid,
  input  wire logic    wr_axis_tlast,
  input  wire logic    wr_axis_tuser,
  // read side
  output wire data_t   rd_axis_tdata,
  output wire keep_t   rd_axis_tkeep,
  output wire logic    rd_axis_tvalid,
  output wire logic    rd_axis_tlast,
  input  wire logic    rd_axis_tready,
  // status
  output wire status_t fifo_status,
  output wire logic    fifo_full
);

  logic      commit_strobe;
  addr_t     commit_addr;
  addr_t     rel_addr;
  logic      rd_en;
  addr_t     rd_addr;
  ram_word_t rd_word;

  ram_wr_if i_ram_wr (.clk(wr_axis_aclk));

  // ----------------------------------------------------------
  // write stage, memory, read stage
  // ----------------------------------------------------------
  frame_writer i_frame_writer (
    .wr_axis_aclk   (wr_axis_aclk),
    .rd_sreset      (rd_sreset),
    .wr_axis_tdata  (wr_axis_tdata),
    .wr_axis_tkeep  (wr_axis_tkeep),
    .wr_axis_tvalid (wr_axis_tvalid),
    .wr_axis_tlast  (wr_axis_tlast),
    .wr_axis_tuser  (wr_axis_tuser),
    .rel_addr       (rel_addr),
    .ram            (i_ram_wr.writer),
    .commit_strobe  (commit_strobe),
    .commit_addr    (commit_addr),
    .fifo_full      (fifo_full),
    .fifo_status    (fifo_status)
  );

  frame_ram i_frame_ram (
    .wr_axis_aclk (wr_axis_aclk),
    .ram          (i_ram_wr.ram),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_word      (rd_word)
  );

  frame_reader i_frame_reader (
    .wr_axis_aclk   (wr_axis_aclk),
    .rd_sreset      (rd_sreset),
    .commit_strobe  (commit_strobe),
    .commit_addr    (commit_addr),
    .rd_word        (rd_word),
    .rd_axis_tready (rd_axis_tready),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rel_addr       (rel_addr),
    .rd_axis_tdata  (rd_axis_tdata),
    .rd_axis_tkeep  (rd_axis_tkeep),
    .rd_axis_tvalid (rd_axis_tvalid),
    .rd_axis_tlast  (rd_axis_tlast)
  );

endmodule

`default_nettype wire

// ==== tb/clk_rst_gen.sv ====
/*
 * clk_rst_gen
 * 100 ns testbench clock and a synchronous reset held for 16 cycles
 */

`default_nettype none

module clk_rst_gen (
  output logic wr_axis_aclk,
  output logic rd_sreset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 16;
  localparam int RELEASE_NS   = 10;

  initial begin
    wr_axis_aclk = 1'b0;
    forever #(PERIOD_NS / 2) wr_axis_aclk = ~wr_axis_aclk;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    rd_sreset = 1'b1;
    repeat (RESET_CYCLES) @(posedge wr_axis_aclk);
    #RELEASE_NS;
    rd_sreset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_axis_frame_fifo.sv ====
/*
 * tb_axis_frame_fifo
 * testbench for the receive frame FIFO: random frames in, scoreboard of
 * kept frames, read beats checked by assertions on the falling edge
 */

`default_nettype none

`include "frame_fifo_config.svh"

module tb_axis_frame_fifo
  import frame_pkg::*;
  import fifo_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH      = 1 << `FIFO_ADDR_WIDTH;
  localparam int SB_SIZE    = 512;
  localparam int STEP_DELAY = 10;
  // all tests together need well under 2000 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  typedef enum logic [1:0] {ready_low, ready_high, ready_random} ready_mode_e;

  logic        wr_axis_aclk;
  logic        rd_sreset;
  data_t       wr_axis_tdata;
  keep_t       wr_axis_tkeep;
  logic        wr_axis_tvalid;
  logic        wr_axis_tlast;
  logic        wr_axis_tuser;
  data_t       rd_axis_tdata;
  keep_t       rd_axis_tkeep;
  logic        rd_axis_tvalid;
  logic        rd_axis_tlast;
  logic        rd_axis_tready;
  status_t     fifo_status;
  logic        fifo_full;
  logic        beat_fire;

  integer      seed;
  string       test_name;
  ready_mode_e ready_mode;
  logic        full_seen;
  int          cycle_cnt = 0;

  // expected beats, written at exp_cnt and consumed at rd_idx
  data_t exp_data [SB_SIZE];
  keep_t exp_keep [SB_SIZE];
  logic  exp_last [SB_SIZE];
  int    exp_cnt;
  int    rd_idx;

  clk_rst_gen i_clk_rst_gen (
    .wr_axis_aclk (wr_axis_aclk),
    .rd_sreset    (rd_sreset)
  );

  axis_frame_fifo i_axis_frame_fifo (
    .wr_axis_aclk   (wr_axis_aclk),
    .rd_sreset      (rd_sreset),
    .wr_axis_tdata  (wr_axis_tdata),
    .wr_axis_tkeep  (wr_axis_tkeep),
    .wr_axis_tvalid (wr_axis_tvalid),
    .wr_axis_tlast  (wr_axis_tlast),
    .wr_axis_tuser  (wr_axis_tuser),
    .rd_axis_tdata  (rd_axis_tdata),
    .rd_axis_tkeep  (rd_axis_tkeep),
    .rd_axis_tvalid (rd_axis_tvalid),
    .rd_axis_tlast  (rd_axis_tlast),
    .rd_axis_tready (rd_axis_tready),
    .fifo_status    (fifo_status),
    .fifo_full      (fifo_full)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // ------------------------------------------------------------
  // scoreboard and read-side checks
  // ------------------------------------------------------------
  assign beat_fire = rd_axis_tvalid & rd_axis_tready;

  // a beat seen at the falling edge is taken at the next rising edge
  always @(posedge wr_axis_aclk) begin
    if (rd_sreset) begin
      rd_idx <= 0;
    end else if (beat_fire) begin
      rd_idx <= rd_idx + 1;
    end
  end

  a_beat_expected: assert property (
    @(negedge wr_axis_aclk) disable iff (rd_sreset)
    beat_fire |-> rd_idx < exp_cnt
  ) else fail_run($sformatf("read beat %0d in %s arrived with no frame left to deliver",
                            rd_idx, test_name));

  a_data_match: assert property (
    @(negedge wr_axis_aclk) disable iff (rd_sreset)
    beat_fire |-> rd_axis_tdata == exp_data[rd_idx]
  ) else fail_run($sformatf("Mismatch %s tdata expected 0x%h actual 0x%h",
                            test_name, exp_data[rd_idx], rd_axis_tdata));

  a_keep_match: assert property (
    @(negedge wr_axis_aclk) disable iff (rd_sreset)
    beat_fire |-> rd_axis_tkeep == exp_keep[rd_idx]
  ) else fail_run($sformatf("Mismatch %s tkeep expected 0x%h actual 0x%h",
                            test_name, exp_keep[rd_idx], rd_axis_tkeep));

  a_last_match: assert property (
    @(negedge wr_axis_aclk) disable iff (rd_sreset)
    beat_fire |-> rd_axis_tlast == exp_last[rd_idx]
  ) else fail_run($sformatf("Mismatch %s tlast expected %0b actual %0b",
                            test_name, exp_last[rd_idx], rd_axis_tlast));

  always @(posedge wr_axis_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run("timeout, the run did not finish within the cycle limit");
    end
  end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------
  // one clock, inputs change a short delay after the edge
  task automatic advance_cycle();
    logic [31:0] rnd;
    @(posedge wr_axis_aclk);
    #STEP_DELAY;
    case (ready_mode)
      ready_low:  rd_axis_tready = 1'b0;
      ready_high: rd_axis_tready = 1'b1;
      default: begin
        rnd = $random(seed);
        rd_axis_tready = rnd[0];
      end
    endcase
  endtask

  task automatic push_expected(input data_t data, input keep_t keep, input logic last);
    if (exp_cnt >= SB_SIZE) begin
      fail_run("scoreboard overflow, too many beats expected");
    end else begin
      exp_data[exp_cnt] = data;
      exp_keep[exp_cnt] = keep;
      exp_last[exp_cnt] = last;
      exp_cnt = exp_cnt + 1;
    end
  endtask

  // user is the last beat's tuser, kept says whether the frame must come out
  task automatic send_frame(input int n_words, input logic user, input logic kept);
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    logic [31:0] rnd_len;
    data_t       data;
    keep_t       keep;
    logic        last_beat;
    int          n_bytes;
    for (int i = 0; i < n_words; i++) begin
      rnd_hi    = $random(seed);
      rnd_lo    = $random(seed);
      data      = {rnd_hi, rnd_lo};
      last_beat = (i == n_words - 1);
      keep      = '1;
      // last beat carries 1 to 8 bytes, packed from byte 0
      if (last_beat) begin
        rnd_len = $random(seed);
        n_bytes = int'(rnd_len[2:0]) + 1;
        keep    = keep >> (`FIFO_KEEP_WIDTH - n_bytes);
      end
      wr_axis_tdata  = data;
      wr_axis_tkeep  = keep;
      wr_axis_tvalid = 1'b1;
      wr_axis_tlast  = last_beat;
      wr_axis_tuser  = last_beat & user;
      if (kept) begin
        push_expected(data, keep, last_beat);
      end
      advance_cycle();
      if (fifo_full) begin
        full_seen = 1'b1;
      end
    end
    wr_axis_tvalid = 1'b0;
    wr_axis_tlast  = 1'b0;
    wr_axis_tuser  = 1'b0;
  endtask

  // random sizes 1 to 9, optionally waiting while the backlog is large
  task automatic send_good_frames(input int count, input int backlog);
    logic [31:0] rnd;
    int          n_words;
    for (int k = 0; k < count; k++) begin
      rnd     = $random(seed);
      n_words = int'(rnd[7:0]) % 9 + 1;
      send_frame(n_words, 1'b1, 1'b1);
      while (backlog > 0 && exp_cnt - rd_idx > backlog) begin
        advance_cycle();
      end
    end
  endtask

  task automatic wait_drained();
    while (rd_idx != exp_cnt) begin
      advance_cycle();
    end
    repeat (3) advance_cycle();
  endtask

  task automatic check_status(input int words_used);
    status_t exp_status;
    logic    exp_full;
    exp_status = status_t'(words_used * (1 << `FIFO_STATUS_WIDTH) / DEPTH);
    exp_full   = (words_used >= DEPTH - `FIFO_FULL_MARGIN);
    assert (fifo_status == exp_status)
      else fail_run($sformatf("Mismatch %s fifo_status expected %0d actual %0d",
                              test_name, exp_status, fifo_status));
    assert (fifo_full == exp_full)
      else fail_run($sformatf("Mismatch %s fifo_full expected %0b actual %0b",
                              test_name, exp_full, fifo_full));
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    seed           = 32'hbdba974c;
    test_name      = "reset";
    ready_mode     = ready_high;
    full_seen      = 1'b0;
    exp_cnt        = 0;
    wr_axis_tdata  = '0;
    wr_axis_tkeep  = '0;
    wr_axis_tvalid = 1'b0;
    wr_axis_tlast  = 1'b0;
    wr_axis_tuser  = 1'b0;
    rd_axis_tready = 1'b0;

    @(negedge rd_sreset);
    advance_cycle();
    assert (!rd_axis_tvalid && !rd_axis_tlast)
      else fail_run("read side is not idle after reset");
    check_status(0);

    // every length once, then random lengths, ready high
    test_name = "good_frames";
    for (int n = 1; n <= 9; n++) begin
      send_frame(n, 1'b1, 1'b1);
    end
    send_good_frames(6, 0);
    wait_drained();

    // tuser low on the last beat drops the frame
    test_name = "bad_user_frame";
    send_frame(4, 1'b1, 1'b1);
    send_frame(5, 1'b0, 1'b0);
    send_frame(3, 1'b1, 1'b1);
    send_frame(1, 1'b0, 1'b0);
    send_frame(2, 1'b1, 1'b1);
    wait_drained();

    test_name  = "random_ready";
    ready_mode = ready_random;
    send_good_frames(16, 24);
    ready_mode = ready_high;
    wait_drained();

    // seven 8-word frames fit, the eighth crosses the threshold
    test_name  = "overflow_drop";
    ready_mode = ready_low;
    repeat (2) advance_cycle();
    for (int k = 0; k < 7; k++) begin
      send_frame(8, 1'b1, 1'b1);
    end
    repeat (3) advance_cycle();
    test_name = "status_level";
    check_status(56);
    test_name = "overflow_drop";
    full_seen = 1'b0;
    send_frame(8, 1'b1, 1'b0);
    repeat (3) advance_cycle();
    assert (full_seen)
      else fail_run("fifo_full never rose while the eighth frame was written");
    test_name = "status_level";
    check_status(56);
    ready_mode = ready_high;
    wait_drained();
    check_status(0);

    test_name = "end_of_run";
    repeat (5) advance_cycle();
    if (rd_idx == exp_cnt && !rd_axis_tvalid) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      fail_run("frames were left undelivered at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
hdl/frame_pkg.sv
hdl/fifo_ctrl_pkg.sv
hdl/ram_wr_if.sv
hdl/frame_writer.sv
hdl/frame_ram.sv
hdl/frame_reader.sv
hdl/axis_frame_fifo.sv
tb/clk_rst_gen.sv
tb/tb_axis_frame_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axis_frame_fifo -f all.f -o tb_axis_frame_fifo &&
  ./obj_dir/tb_axis_frame_fifo || exit 1
